//--- hdl/periph_bus_config.svh
//**************************************************
// one shared base tag for every region, each region is a 4 KiB window
// the address split must add up to PB_ADDR_WIDTH
//**************************************************
`ifndef PERIPH_BUS_CONFIG_SVH
`define PERIPH_BUS_CONFIG_SVH

//**************************************************
// bus widths
//**************************************************

// address and data are one word each
`define PB_ADDR_WIDTH 32
`define PB_DATA_WIDTH 32

//**************************************************
// address map
//**************************************************

// field widths of the address, from the top down
`define PB_TAG_WIDTH    16
`define PB_REGION_WIDTH 4
`define PB_OFFSET_WIDTH 12

// upper address bits that every mapped access must carry
`define PB_BASE_TAG 16'h1A10

// region numbers inside the base tag window
`define PB_REGION_GPIO  4'd0
`define PB_REGION_TIMER 4'd1

//**************************************************
// peripheral sizing
//**************************************************

`define PB_GPIO_WIDTH 16

`endif

//--- hdl/periph_bus_pkg.sv
//**************************************************
// APB bundles without pprot and pstrb
//**************************************************

`include "periph_bus_config.svh"

package periph_bus_pkg;

  // requester to completer, one per bus port
  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`PB_ADDR_WIDTH-1:0] paddr;
    logic [`PB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  // completer to requester
  // prdata and pslverr only mean something while pready is high
  typedef struct packed {
    logic                      pready;
    logic                      pslverr;
    logic [`PB_DATA_WIDTH-1:0] prdata;
  } apb_rsp_t;

  // idle values, handy for default assignments
  localparam apb_req_t APB_REQ_IDLE = '0;
  localparam apb_rsp_t APB_RSP_IDLE = '0;

  // the error answer given for an unmapped address
  localparam apb_rsp_t APB_RSP_ERROR = '{
    pready:  1'b1,
    pslverr: 1'b1,
    prdata:  '0
  };

endpackage

//--- hdl/periph_map_pkg.sv
//**************************************************
// address layout is tag, region, offset from msb to lsb
//**************************************************

`include "periph_bus_config.svh"

package periph_map_pkg;

  // region numbers not listed here are unmapped
  typedef enum logic [`PB_REGION_WIDTH-1:0] {
    region_gpio  = `PB_REGION_GPIO,
    region_timer = `PB_REGION_TIMER
  } periph_region_e;

  typedef struct packed {
    logic [`PB_TAG_WIDTH-1:0]    tag;
    periph_region_e              region;
    logic [`PB_OFFSET_WIDTH-1:0] offset;
  } periph_addr_fields_t;

  // the node reads tag and region, the peripherals only the offset
  typedef union packed {
    logic [`PB_ADDR_WIDTH-1:0] flat;
    periph_addr_fields_t       fields;
  } periph_addr_u;

endpackage

//--- hdl/apb_periph_node.sv
//**************************************************
// routes one APB requester to the GPIO or timer region
// unmapped addresses get pslverr in the first access cycle
//**************************************************
`timescale 1ns/100ps

`include "periph_bus_config.svh"

module apb_periph_node
  import periph_bus_pkg::*;
  import periph_map_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  input  apb_req_t req,
  output apb_rsp_t rsp,
  output apb_req_t gpio_req,
  input  apb_rsp_t gpio_rsp,
  output apb_req_t timer_req,
  input  apb_rsp_t timer_rsp
);

  periph_addr_u addr;
  logic         tag_ok;
  logic         hit_gpio;
  logic         hit_timer;
  logic         unmapped;
  logic         err_ack;
  logic         err_done_q;

  //**************************************************
  // address decode
  //**************************************************

  assign addr.flat = req.paddr;
  assign tag_ok    = (addr.fields.tag == `PB_BASE_TAG);

  assign hit_gpio  = req.psel && tag_ok && (addr.fields.region == region_gpio);
  assign hit_timer = req.psel && tag_ok && (addr.fields.region == region_timer);

  // selected but matching no region
  assign unmapped  = req.psel && !hit_gpio && !hit_timer;

  //**************************************************
  // request steering
  //**************************************************

  // every peripheral sees the same request, only psel differs
  always_comb begin
    gpio_req       = req;
    gpio_req.psel  = hit_gpio;
    timer_req      = req;
    timer_req.psel = hit_timer;
  end

  //**************************************************
  // error answer for unmapped addresses
  //**************************************************

  // answer once, in the first access cycle of the transfer
  assign err_ack = unmapped && req.penable && !err_done_q;

  // the flag drops again as soon as penable goes low, which is the
  // setup cycle of the next transfer or an idle cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      err_done_q <= 1'b0;
    end else if (!req.penable) begin
      err_done_q <= 1'b0;
    end else if (err_ack) begin
      err_done_q <= 1'b1;
    end
  end

  //**************************************************
  // response mux
  //**************************************************

  always_comb begin
    rsp = APB_RSP_IDLE;
    if (hit_gpio) begin
      rsp = gpio_rsp;
    end else if (hit_timer) begin
      rsp = timer_rsp;
    end else if (err_ack) begin
      rsp = APB_RSP_ERROR;
    end
  end

endmodule

//--- hdl/gpio_regs.sv
//**************************************************
// zero wait states, gpio_in passes a two-flop synchronizer
//**************************************************
`timescale 1ns/100ps

`include "periph_bus_config.svh"

module gpio_regs
  import periph_bus_pkg::*;
  import periph_map_pkg::*;
#(
  parameter int N_GPIO = `PB_GPIO_WIDTH
) (
  input  logic              clk_i,
  input  logic              rst_n,
  input  apb_req_t          req,
  output apb_rsp_t          rsp,
  input  logic [N_GPIO-1:0] gpio_in,
  output logic [N_GPIO-1:0] gpio_out,
  output logic [N_GPIO-1:0] gpio_oe
);

  localparam logic [`PB_OFFSET_WIDTH-1:0] OFS_DIR = 'h0;
  localparam logic [`PB_OFFSET_WIDTH-1:0] OFS_OUT = 'h4;
  localparam logic [`PB_OFFSET_WIDTH-1:0] OFS_IN  = 'h8;

  periph_addr_u      addr;
  logic              access;
  logic [N_GPIO-1:0] dir_q;
  logic [N_GPIO-1:0] out_q;
  logic [N_GPIO-1:0] sync1_q;
  logic [N_GPIO-1:0] sync2_q;

  assign addr.flat = req.paddr;
  assign access    = req.psel && req.penable;

  // register writes land in the access cycle since pready is always high
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (access && req.pwrite) begin
      if (addr.fields.offset == OFS_DIR) dir_q <= req.pwdata[N_GPIO-1:0];
      if (addr.fields.offset == OFS_OUT) out_q <= req.pwdata[N_GPIO-1:0];
    end
  end

  // the pins are asynchronous to clk_i
  always_ff @(posedge clk_i) begin
    sync1_q <= gpio_in;
    sync2_q <= sync1_q;
  end

  always_comb begin
    rsp         = APB_RSP_IDLE;
    rsp.pready  = access;
    if (access && !req.pwrite) begin
      case (addr.fields.offset)
        OFS_DIR: rsp.prdata[N_GPIO-1:0] = dir_q;
        OFS_OUT: rsp.prdata[N_GPIO-1:0] = out_q;
        OFS_IN:  rsp.prdata[N_GPIO-1:0] = sync2_q;
        default: rsp.prdata             = '0;
      endcase
    end
  end

  // pins configured as inputs never drive a one
  assign gpio_oe  = dir_q;
  assign gpio_out = out_q & dir_q;

endmodule

//--- hdl/event_timer.sv
//**************************************************
// every access takes one wait state, reads are registered
// the count wraps to zero on a compare match
//**************************************************
`timescale 1ns/100ps

`include "periph_bus_config.svh"

module event_timer
  import periph_bus_pkg::*;
  import periph_map_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  input  apb_req_t req,
  output apb_rsp_t rsp,
  output logic     irq
);

  localparam logic [`PB_OFFSET_WIDTH-1:0] OFS_CTRL   = 'h0;
  localparam logic [`PB_OFFSET_WIDTH-1:0] OFS_CMP    = 'h4;
  localparam logic [`PB_OFFSET_WIDTH-1:0] OFS_COUNT  = 'h8;
  localparam logic [`PB_OFFSET_WIDTH-1:0] OFS_STATUS = 'hC;

  periph_addr_u              addr;
  logic                      access;
  logic                      wr_en;
  logic                      count_clr;
  logic                      match;
  logic                      enable_q;
  logic                      match_q;
  logic                      ready_q;
  logic [`PB_DATA_WIDTH-1:0] cmp_q;
  logic [`PB_DATA_WIDTH-1:0] count_q;
  logic [`PB_DATA_WIDTH-1:0] rdata;
  logic [`PB_DATA_WIDTH-1:0] rdata_q;

  assign addr.flat = req.paddr;
  assign access    = req.psel && req.penable;

  // writes take effect in the second access cycle, where pready is high
  assign wr_en     = access && ready_q && req.pwrite;
  assign count_clr = wr_en && (addr.fields.offset == OFS_CTRL) && req.pwdata[1];
  assign match     = enable_q && (count_q == cmp_q);

  //**************************************************
  // access handshake
  //**************************************************

  // ready_q is high only in the second access cycle of a transfer
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access && !ready_q;
    end
  end

  always_comb begin
    case (addr.fields.offset)
      OFS_CTRL:   rdata = {{(`PB_DATA_WIDTH-1){1'b0}}, enable_q};
      OFS_CMP:    rdata = cmp_q;
      OFS_COUNT:  rdata = count_q;
      OFS_STATUS: rdata = {{(`PB_DATA_WIDTH-1){1'b0}}, match_q};
      default:    rdata = '0;
    endcase
  end

  // sampled in the first access cycle
  always_ff @(posedge clk_i) begin
    if (access && !ready_q) begin
      rdata_q <= req.pwrite ? '0 : rdata;
    end
  end

  always_comb begin
    rsp        = APB_RSP_IDLE;
    rsp.pready = ready_q;
    if (ready_q) rsp.prdata = rdata_q;
  end

  //**************************************************
  // registers and counter
  //**************************************************

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
    end else if (wr_en) begin
      if (addr.fields.offset == OFS_CTRL) enable_q <= req.pwdata[0];
      if (addr.fields.offset == OFS_CMP)  cmp_q    <= req.pwdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (count_clr || match) begin
      count_q <= '0;
    end else if (enable_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  // a new match wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      match_q <= 1'b0;
    end else if (match) begin
      match_q <= 1'b1;
    end else if (wr_en && (addr.fields.offset == OFS_STATUS) && req.pwdata[0]) begin
      match_q <= 1'b0;
    end
  end

  assign irq = match_q;

endmodule

//--- hdl/periph_bus_wrap.sv
//**************************************************
// GPIO at region 0 and timer at region 1 under PB_BASE_TAG
//**************************************************
`timescale 1ns/100ps

`include "periph_bus_config.svh"

module periph_bus_wrap
  import periph_bus_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n,
  input  apb_req_t                  req,
  output apb_rsp_t                  rsp,
  input  logic [`PB_GPIO_WIDTH-1:0] gpio_in,
  output logic [`PB_GPIO_WIDTH-1:0] gpio_out,
  output logic [`PB_GPIO_WIDTH-1:0] gpio_oe,
  output logic                      timer_irq
);

  apb_req_t gpio_req;
  apb_rsp_t gpio_rsp;
  apb_req_t timer_req;
  apb_rsp_t timer_rsp;

  //**************************************************
  // address node
  //**************************************************

  apb_periph_node node_i (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .req      (req),
    .rsp      (rsp),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp),
    .timer_req(timer_req),
    .timer_rsp(timer_rsp)
  );

  //**************************************************
  // peripherals
  //**************************************************

  gpio_regs #(
    .N_GPIO(`PB_GPIO_WIDTH)
  ) gpio_i (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .req     (gpio_req),
    .rsp     (gpio_rsp),
    .gpio_in (gpio_in),
    .gpio_out(gpio_out),
    .gpio_oe (gpio_oe)
  );

  event_timer timer_i (
    .clk_i(clk_i),
    .rst_n(rst_n),
    .req  (timer_req),
    .rsp  (timer_rsp),
    .irq  (timer_irq)
  );

endmodule

//--- tb/periph_bus_asserts.sv
//**************************************************
// bound into apb_periph_node, watches the upstream port
//**************************************************
`timescale 1ns/100ps

module periph_bus_asserts
  import periph_bus_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n,
  input apb_req_t req,
  input apb_rsp_t rsp,
  input apb_req_t gpio_req,
  input apb_req_t timer_req
);

  penable_needs_psel: assert property (@(posedge clk_i) disable iff (!rst_n)
    req.penable |-> req.psel)
    else $error("penable high without psel");

  // a waiting access must not change its request
  req_stable_while_waiting: assert property (@(posedge clk_i) disable iff (!rst_n)
    (req.psel && req.penable && !rsp.pready) |=> $stable(req))
    else $error("request changed while pready was low");

  one_peripheral_selected: assert property (@(posedge clk_i) disable iff (!rst_n)
    !(gpio_req.psel && timer_req.psel))
    else $error("both peripherals selected at once");

  slverr_only_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n)
    rsp.pslverr |-> rsp.pready)
    else $error("pslverr high without pready");

endmodule

//--- tb/periph_bus_tb.sv
//**************************************************
// drives periph_bus_wrap over APB on the falling clock edge
// the timer count is only predicted while the timer is stopped
//**************************************************
`timescale 1ns/100ps

`include "periph_bus_config.svh"

module periph_bus_tb
  import periph_bus_pkg::*;
();

  localparam int CLK_PERIOD        = 20;
  localparam int QUARTER           = CLK_PERIOD / 4;
  localparam int MAX_XFERS         = 40;
  localparam int TIMER_WAIT_CYCLES = 64;
  localparam int TIMEOUT_CYCLES    = MAX_XFERS * 200 + TIMER_WAIT_CYCLES;
  localparam logic [31:0] SEED     = 32'h2354_73c6;
  localparam int W                 = `PB_GPIO_WIDTH;

  localparam logic [31:0] GPIO_BASE  = {`PB_BASE_TAG, `PB_REGION_GPIO, 12'h000};
  localparam logic [31:0] TIMER_BASE = {`PB_BASE_TAG, `PB_REGION_TIMER, 12'h000};

  logic         clk_i;
  logic         rst_n;
  apb_req_t     req;
  apb_rsp_t     rsp;
  logic [W-1:0] gpio_in;
  logic [W-1:0] gpio_out;
  logic [W-1:0] gpio_oe;
  logic         timer_irq;

  // shadow copy of the peripheral registers
  logic [W-1:0] sh_dir;
  logic [W-1:0] sh_out;
  logic [W-1:0] sh_pins;
  logic         sh_tmr_en;
  logic         sh_status;
  logic [31:0]  sh_cmp;

  int n_errors;
  int n_checks;
  int n_tests;

  // reads waiting for the comparison process
  logic [31:0] addr_q[$];
  apb_rsp_t    got_q[$];
  apb_rsp_t    exp_q[$];
  logic [31:0] cmp_addr;
  apb_rsp_t    cmp_got;
  apb_rsp_t    cmp_exp;

  periph_bus_wrap dut_i (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .req      (req),
    .rsp      (rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .timer_irq(timer_irq)
  );

  bind apb_periph_node periph_bus_asserts asserts_i (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .req      (req),
    .rsp      (rsp),
    .gpio_req (gpio_req),
    .timer_req(timer_req)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //**************************************************
  // reference model
  //**************************************************

  function automatic apb_rsp_t expected_read(input logic [31:0] addr);
    apb_rsp_t    e;
    logic [15:0] tag;
    logic [3:0]  region;
    logic [11:0] offset;
    tag       = addr[31:16];
    region    = addr[15:12];
    offset    = addr[11:0];
    e         = '0;
    e.pready  = 1'b1;
    if (tag != `PB_BASE_TAG ||
        (region != `PB_REGION_GPIO && region != `PB_REGION_TIMER)) begin
      e.pslverr = 1'b1;
    end else if (region == `PB_REGION_GPIO) begin
      case (offset)
        12'h000: e.prdata = 32'(sh_dir);
        12'h004: e.prdata = 32'(sh_out);
        12'h008: e.prdata = 32'(sh_pins);
        default: e.prdata = '0;
      endcase
    end else begin
      case (offset)
        12'h000: e.prdata = 32'(sh_tmr_en);
        12'h004: e.prdata = sh_cmp;
        12'h00C: e.prdata = 32'(sh_status);
        // a stopped and cleared count reads zero just as unused offsets do
        default: e.prdata = '0;
      endcase
    end
    return e;
  endfunction

  // the timer adds one wait state and everything else answers at once
  function automatic int expected_waits(input logic [31:0] addr);
    if (addr[31:16] == `PB_BASE_TAG && addr[15:12] == `PB_REGION_TIMER) begin
      return 2;
    end
    return 1;
  endfunction

  task automatic update_model(input logic [31:0] addr, input logic [31:0] wdata);
    if (addr[31:16] == `PB_BASE_TAG && addr[15:12] == `PB_REGION_GPIO) begin
      case (addr[11:0])
        12'h000: sh_dir = wdata[W-1:0];
        12'h004: sh_out = wdata[W-1:0];
        default: ;
      endcase
    end else if (addr[31:16] == `PB_BASE_TAG && addr[15:12] == `PB_REGION_TIMER) begin
      case (addr[11:0])
        12'h000: sh_tmr_en = wdata[0];
        12'h004: sh_cmp = wdata;
        12'h00C: if (wdata[0]) sh_status = 1'b0;
        default: ;
      endcase
    end
  endtask

  //**************************************************
  // checking and bus tasks
  //**************************************************

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic apb_xfer(input logic write, input logic [31:0] addr,
                          input logic [31:0] wdata, output apb_rsp_t r);
    int   cycles;
    logic done;
    @(negedge clk_i);
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = write;
    req.paddr   = addr;
    req.pwdata  = wdata;
    @(negedge clk_i);
    req.penable = 1'b1;
    cycles      = 0;
    done        = 1'b0;
    while (!done) begin
      // rsp has settled a quarter period before the rising edge
      #(QUARTER);
      r = rsp;
      cycles++;
      done = r.pready;
      @(negedge clk_i);
    end
    req = APB_REQ_IDLE;
    check_value($sformatf("access cycles at 0x%08h", addr), 32'(cycles),
                32'(expected_waits(addr)));
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
    apb_rsp_t r;
    apb_rsp_t e;
    e = expected_read(addr);
    apb_xfer(1'b1, addr, wdata, r);
    check_value($sformatf("write pslverr at 0x%08h", addr), 32'(r.pslverr), 32'(e.pslverr));
    update_model(addr, wdata);
  endtask

  task automatic apb_read(input logic [31:0] addr);
    apb_rsp_t r;
    apb_rsp_t e;
    e = expected_read(addr);
    apb_xfer(1'b0, addr, '0, r);
    addr_q.push_back(addr);
    got_q.push_back(r);
    exp_q.push_back(e);
  endtask

  // compares every finished read against the model
  always @(posedge clk_i) begin
    while (got_q.size() > 0) begin
      cmp_addr = addr_q.pop_front();
      cmp_got  = got_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      check_value($sformatf("prdata at 0x%08h", cmp_addr), cmp_got.prdata, cmp_exp.prdata);
      check_value($sformatf("pslverr at 0x%08h", cmp_addr), 32'(cmp_got.pslverr),
                  32'(cmp_exp.pslverr));
    end
  end

  task automatic report_test(input string name, input int errs_before);
    // let queued reads reach the comparison process first
    @(posedge clk_i);
    @(negedge clk_i);
    n_tests++;
    if (n_errors == errs_before) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      $display("test %0d %s: FAILED, %0d mismatches", n_tests, name, n_errors - errs_before);
    end
  endtask

  //**************************************************
  // tests
  //**************************************************

  task automatic test_gpio_regs();
    int e0;
    e0 = n_errors;
    apb_write(GPIO_BASE + 32'h0, $urandom());
    apb_write(GPIO_BASE + 32'h4, $urandom());
    apb_read(GPIO_BASE + 32'h0);
    apb_read(GPIO_BASE + 32'h4);
    check_value("gpio_oe", 32'(gpio_oe), 32'(sh_dir));
    check_value("gpio_out", 32'(gpio_out), 32'(sh_out & sh_dir));
    report_test("gpio registers", e0);
  endtask

  task automatic test_gpio_input();
    int e0;
    e0      = n_errors;
    sh_pins = W'($urandom());
    gpio_in = sh_pins;
    repeat (3) @(negedge clk_i);
    apb_read(GPIO_BASE + 32'h8);
    report_test("gpio input", e0);
  endtask

  task automatic test_unmapped();
    int e0;
    e0 = n_errors;
    // wrong base tag and then region 2
    apb_write(32'h1B10_0000, $urandom());
    apb_write({`PB_BASE_TAG, 4'd2, 12'h004}, $urandom());
    apb_read(32'h1B10_0000);
    apb_read({`PB_BASE_TAG, 4'd2, 12'h000});
    apb_read(TIMER_BASE + 32'h10);
    apb_read(GPIO_BASE + 32'h0);
    apb_read(GPIO_BASE + 32'h4);
    report_test("unmapped access", e0);
  endtask

  task automatic test_timer_match();
    int          e0;
    int          n;
    logic [31:0] cmp;
    e0  = n_errors;
    cmp = 32'd3 + ($urandom() % 32'd10);
    apb_write(TIMER_BASE + 32'h0, 32'h2);
    apb_write(TIMER_BASE + 32'h4, cmp);
    apb_write(TIMER_BASE + 32'h0, 32'h1);
    n = 0;
    while (!timer_irq && n < int'(cmp) + 4) begin
      @(negedge clk_i);
      n++;
    end
    check_value("timer_irq within compare+4 cycles", 32'(timer_irq), 32'd1);
    sh_status = 1'b1;
    apb_read(TIMER_BASE + 32'hC);
    // stop first so that no new match races the status clear
    apb_write(TIMER_BASE + 32'h0, 32'h0);
    apb_write(TIMER_BASE + 32'hC, 32'h1);
    apb_read(TIMER_BASE + 32'hC);
    check_value("timer_irq after status clear", 32'(timer_irq), 32'd0);
    report_test("timer match", e0);
  endtask

  task automatic test_timer_count();
    int       e0;
    apb_rsp_t r;
    e0 = n_errors;
    apb_write(TIMER_BASE + 32'h4, 32'd1000);
    apb_write(TIMER_BASE + 32'h0, 32'h1);
    // the count has moved away from zero before the clear below
    repeat (5) @(negedge clk_i);
    apb_write(TIMER_BASE + 32'h0, 32'h2);
    apb_read(TIMER_BASE + 32'h8);
    apb_read(TIMER_BASE + 32'h8);
    apb_write(TIMER_BASE + 32'h0, 32'h1);
    repeat (5) @(negedge clk_i);
    apb_xfer(1'b0, TIMER_BASE + 32'h8, '0, r);
    check_value("running count is nonzero", 32'(r.prdata != 0), 32'd1);
    check_value("running count within compare", 32'(r.prdata <= sh_cmp), 32'd1);
    apb_write(TIMER_BASE + 32'h0, 32'h2);
    report_test("timer count", e0);
  endtask

  // every transfer checks its own access cycles and this one mixes all kinds
  task automatic test_wait_states();
    int e0;
    e0 = n_errors;
    apb_read(GPIO_BASE + 32'h0);
    apb_read(TIMER_BASE + 32'h4);
    apb_read(32'h0000_0004);
    apb_write(TIMER_BASE + 32'h4, 32'd20);
    report_test("wait states", e0);
  endtask

  initial begin
    void'($urandom(SEED));
    clk_i     = 1'b0;
    rst_n     = 1'b0;
    req       = APB_REQ_IDLE;
    gpio_in   = '0;
    sh_dir    = '0;
    sh_out    = '0;
    sh_pins   = '0;
    sh_tmr_en = 1'b0;
    sh_status = 1'b0;
    sh_cmp    = '0;
    n_errors  = 0;
    n_checks  = 0;
    n_tests   = 0;
    repeat (2) @(negedge clk_i);
    rst_n = 1'b1;
    test_gpio_regs();
    test_gpio_input();
    test_unmapped();
    test_timer_match();
    test_timer_count();
    test_wait_states();
    repeat (2) @(negedge clk_i);
    $display("summary: %0d tests, %0d checks, %0d mismatches", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: the run was still busy after %0d cycles, a transfer never completed",
             TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/periph_bus_pkg.sv
hdl/periph_map_pkg.sv
hdl/apb_periph_node.sv
hdl/gpio_regs.sv
hdl/event_timer.sv
hdl/periph_bus_wrap.sv
tb/periph_bus_asserts.sv
tb/periph_bus_tb.sv

//--- Makefile
# Verilator build and run for the peripheral bus testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= periph_bus_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failures found
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failures"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit $$status; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
